// ==== verilog/missile_pkg.sv ====
package missile_pkg;

	////////////////////
	// widths
	////////////////////
	localparam int addr_w = 16;
	localparam int data_w = 8;
	localparam int vram_addr_w = 14;
	localparam int dot_w = 9;
	localparam int line_w = 8;

	////////////////////
	// frame geometry
	////////////////////
	// dots per line, incl. horizontal blank
	localparam logic [dot_w-1:0] line_dots = 9'd320;
	localparam logic [dot_w-1:0] active_dots = 9'd256;
	localparam int frame_lines = 256;
	// lines 0..24 blanked
	localparam logic [line_w-1:0] vblank_lines = 8'd25;
	localparam logic [dot_w-1:0] hsync_start = 9'd272;
	localparam logic [dot_w-1:0] hsync_end = 9'd303;
	localparam logic [line_w-1:0] vsync_start = 8'd4;
	localparam logic [line_w-1:0] vsync_end = 8'd7;
	// bottom 32 lines carry the third colour bit
	localparam logic [line_w-1:0] third_colour_line = 8'd224;

	////////////////////
	// address map
	////////////////////
	// out latch on write, in0 on read, same page
	localparam logic [7:0] page_out = 8'h48;
	localparam logic [7:0] page_in0 = 8'h48;
	localparam logic [7:0] page_in1 = 8'h49;
	localparam logic [7:0] page_colour = 8'h4B;
	localparam logic [addr_w-1:0] ram_top = 16'h4000;
	// addr[15:13] for third colour access
	localparam logic [2:0] third_colour_page = 3'b111;

	// one bus cycle from the master
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic write;
		logic read;
		logic madsel;
	} bus_req_t;

	typedef struct packed {
		logic ram;
		logic pixel_2col;
		logic pixel_3col;
		logic colour;
		logic in0;
		logic in1;
		logic out_latch;
	} chip_sel_t;

	typedef struct packed {
		logic [dot_w-1:0] dot;
		logic [line_w-1:0] line;
		logic h_blank;
		logic v_blank;
		logic third_zone;
		logic ce_5m;
	} scan_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef logic [2:0] colnum_t;
	typedef logic [3:0] palette_t;

	// operator switches, active high
	typedef struct packed {
		logic coin;
		logic start_1;
		logic start_2;
		logic fire_l_1;
		logic fire_c_1;
		logic fire_r_1;
		logic fire_l_2;
		logic fire_c_2;
		logic fire_r_2;
	} buttons_t;

	// quadrature-style clock and direction per axis
	typedef struct packed {
		logic v_clk;
		logic v_dir;
		logic h_clk;
		logic h_dir;
	} trackball_t;

endpackage

// ==== verilog/scan_timer.sv ====
`timescale 1ns/1ns

module scan_timer (
	input logic clk_10M,
	input logic reset,
	output missile_pkg::scan_t scan,
	output logic h_sync,
	output logic v_sync
);

	logic ce_5m;
	logic [missile_pkg::dot_w-1:0] dot;
	logic [missile_pkg::line_w-1:0] line;
	logic end_of_line;

	assign end_of_line = dot == missile_pkg::line_dots - 1'b1;

	////////////////////
	// dot and line counters
	////////////////////
	// ce_5m high every second clock, counters step with it
	always_ff @(posedge clk_10M or posedge reset)
	begin
		if (reset)
		begin
			ce_5m <= 1'b0;
			dot <= '0;
			line <= '0;
		end
		else
		begin
			ce_5m <= !ce_5m;
			if (ce_5m)
			begin
				if (end_of_line)
				begin
					dot <= '0;
					// wrap at end of frame
					if (line == missile_pkg::frame_lines - 1)
						line <= '0;
					else
						line <= line + 1'b1;
				end
				else
				begin
					dot <= dot + 1'b1;
				end
			end
		end
	end

	// blanking and zone flags straight off the counts
	always_comb
	begin
		scan.dot = dot;
		scan.line = line;
		scan.h_blank = dot >= missile_pkg::active_dots;
		scan.v_blank = line < missile_pkg::vblank_lines;
		scan.third_zone = line >= missile_pkg::third_colour_line;
		scan.ce_5m = ce_5m;
	end

	assign h_sync = dot >= missile_pkg::hsync_start && dot <= missile_pkg::hsync_end;
	assign v_sync = line >= missile_pkg::vsync_start && line <= missile_pkg::vsync_end;

	// line length must hold across every step of the counter
	dot_in_range: assert property (@(posedge clk_10M) disable iff (reset)
		dot < missile_pkg::line_dots);

endmodule

// ==== verilog/address_decoder.sv ====
`timescale 1ns/1ns

module address_decoder (
	input missile_pkg::bus_req_t req,
	output missile_pkg::chip_sel_t sel
);

	logic [7:0] page;
	logic third_page;

	assign page = req.addr[15:8];
	// top three address bits pick the third colour area
	assign third_page = req.addr[15:13] == missile_pkg::third_colour_page;

	////////////////////
	// chip selects
	////////////////////
	always_comb
	begin
		sel = '0;
		if (req.madsel)
		begin
			// indirect access, bitmap pixels only
			sel.pixel_3col = third_page;
			sel.pixel_2col = !third_page;
		end
		else
		begin
			// plain byte ram
			sel.ram = req.addr < missile_pkg::ram_top;
			sel.colour = page == missile_pkg::page_colour;
			// in0 on reads, control latch on writes
			sel.in0 = page == missile_pkg::page_in0 && !req.write;
			sel.in1 = page == missile_pkg::page_in1;
			sel.out_latch = page == missile_pkg::page_out && req.write;
		end
	end

endmodule

// ==== verilog/bitmap_ram.sv ====
`timescale 1ns/1ns

module bitmap_ram (
	input logic clk_10M,
	input missile_pkg::bus_req_t req,
	input missile_pkg::chip_sel_t sel,
	input logic [missile_pkg::vram_addr_w-1:0] video_addr,
	output logic [missile_pkg::data_w-1:0] video_data,
	output logic [missile_pkg::data_w-1:0] cpu_data
);

	logic [missile_pkg::data_w-1:0] mem [0:2**missile_pkg::vram_addr_w-1];
	logic [missile_pkg::vram_addr_w-1:0] cpu_addr;
	logic [missile_pkg::data_w-1:0] bit_mask;
	logic [missile_pkg::data_w-1:0] wr_byte;
	logic cpu_we;
	logic [missile_pkg::data_w-1:0] cpu_q;
	logic [missile_pkg::data_w-1:0] video_q;
	logic mode_2col_q;
	logic mode_3col_q;
	logic [2:0] bit_q;

	////////////////////
	// cpu address mapping
	////////////////////
	always_comb
	begin
		if (sel.pixel_3col)
			// 32 lines of 256 bits folded into the spare 1K
			cpu_addr = {3'b000, req.addr[11], !req.addr[11], req.addr[10:3], req.addr[12]};
		else if (sel.pixel_2col)
			// four pixels per byte
			cpu_addr = req.addr[15:2];
		else
			cpu_addr = req.addr[13:0];
	end

	// write mask, was the L6 prom
	always_comb
	begin
		if (sel.pixel_3col)
			bit_mask = 8'h01 << req.addr[2:0];
		else if (sel.pixel_2col)
			// one bit in each nibble
			bit_mask = 8'h11 << req.addr[1:0];
		else
			bit_mask = 8'hFF;
	end

	// data replicated so any masked bit sees the right value
	always_comb
	begin
		if (sel.pixel_3col)
			wr_byte = {8{req.wdata[5]}};
		else if (sel.pixel_2col)
			wr_byte = {{4{req.wdata[7]}}, {4{req.wdata[6]}}};
		else
			wr_byte = req.wdata;
	end

	assign cpu_we = req.write && (sel.ram || sel.pixel_2col || sel.pixel_3col);

	////////////////////
	// dual port store
	////////////////////
	always_ff @(posedge clk_10M)
	begin
		for (int i = 0; i < missile_pkg::data_w; i++)
		begin
			if (cpu_we && bit_mask[i])
				mem[cpu_addr][i] <= wr_byte[i];
		end
		cpu_q <= mem[cpu_addr];
		video_q <= mem[video_addr];
		// access mode and bit index follow the data
		mode_2col_q <= sel.pixel_2col;
		mode_3col_q <= sel.pixel_3col;
		bit_q <= req.addr[2:0];
	end

	assign video_data = video_q;

	// pixel read-back, unused bits read as ones
	always_comb
	begin
		if (mode_3col_q)
			cpu_data = {2'b11, cpu_q[bit_q], 5'b11111};
		else if (mode_2col_q)
			cpu_data = {cpu_q[{1'b1, bit_q[1:0]}], cpu_q[{1'b0, bit_q[1:0]}], 6'b111111};
		else
			cpu_data = cpu_q;
	end

	// decoder keeps byte and pixel access apart
	sel_exclusive: assert property (@(posedge clk_10M)
		!(sel.ram && (sel.pixel_2col || sel.pixel_3col)));

endmodule

// ==== verilog/pixel_shifter.sv ====
`timescale 1ns/1ns

module pixel_shifter (
	input logic clk_10M,
	input logic reset,
	input missile_pkg::scan_t scan,
	input logic [missile_pkg::data_w-1:0] video_data,
	output logic [missile_pkg::vram_addr_w-1:0] video_addr,
	output missile_pkg::colnum_t colnum
);

	// fetch runs three dots ahead of the display
	localparam logic [missile_pkg::dot_w-1:0] fetch_lead = 9'd3;

	logic [missile_pkg::dot_w-1:0] ahead;
	logic wrap;
	logic [missile_pkg::dot_w-1:0] fetch_x;
	logic [missile_pkg::line_w-1:0] fetch_line;
	logic fetch_zone;
	logic [missile_pkg::vram_addr_w-1:0] addr_2col;
	logic [missile_pkg::vram_addr_w-1:0] addr_3col;
	logic [missile_pkg::data_w-1:0] byte_2col;
	logic [3:0] nib_hi;
	logic [3:0] nib_lo;
	logic [7:0] third_bits;

	////////////////////
	// fetch position
	////////////////////
	assign ahead = scan.dot + fetch_lead;
	// past the end of line, fetch for next line
	assign wrap = ahead >= missile_pkg::line_dots;
	assign fetch_x = wrap ? ahead - missile_pkg::line_dots : ahead;
	assign fetch_line = wrap ? scan.line + 1'b1 : scan.line;
	assign fetch_zone = wrap ? fetch_line >= missile_pkg::third_colour_line : scan.third_zone;

	// same mapping the cpu side uses
	assign addr_2col = {fetch_line, fetch_x[7:2]};
	assign addr_3col = {3'b000, fetch_line[3], !fetch_line[3], fetch_line[2:0],
		fetch_x[7:3], fetch_line[4]};

	////////////////////
	// fetch and shift
	////////////////////
	// 2col addr on dot 1 of group, data held on dot 2, load on dot 3
	// 3col addr on dot 6, load on dot 7
	always_ff @(posedge clk_10M or posedge reset)
	begin
		if (reset)
		begin
			video_addr <= '0;
			nib_hi <= '0;
			nib_lo <= '0;
			third_bits <= '0;
		end
		else if (scan.ce_5m)
		begin
			if (scan.dot[1:0] == 2'd1)
				video_addr <= addr_2col;
			else if (scan.dot[2:0] == 3'd6 && fetch_zone)
				video_addr <= addr_3col;

			if (scan.dot[1:0] == 2'd3)
			begin
				nib_hi <= byte_2col[7:4];
				nib_lo <= byte_2col[3:0];
			end
			else
			begin
				nib_hi <= nib_hi >> 1;
				nib_lo <= nib_lo >> 1;
			end

			// third bit forced low outside the bottom zone
			if (scan.dot[2:0] == 3'd7)
				third_bits <= fetch_zone ? video_data : '0;
			else
				third_bits <= third_bits >> 1;
		end
	end

	// park 2col byte so the port is free for the 3col fetch
	always_ff @(posedge clk_10M)
	begin
		if (scan.ce_5m && scan.dot[1:0] == 2'd2)
			byte_2col <= video_data;
	end

	assign colnum = {nib_hi[0], nib_lo[0], third_bits[0]};

endmodule

// ==== verilog/colour_palette.sv ====
`timescale 1ns/1ns

module colour_palette (
	input logic clk_10M,
	input logic reset,
	input missile_pkg::scan_t scan,
	input missile_pkg::bus_req_t req,
	input logic colour_sel,
	input missile_pkg::colnum_t colnum,
	output missile_pkg::palette_t palette_data,
	output missile_pkg::rgb_t rgb
);

	missile_pkg::palette_t cram [0:7];
	logic bus_side;
	logic [2:0] cram_addr;
	missile_pkg::rgb_t rgb_latch;

	// bus owns the colour ram only in vertical blank
	assign bus_side = scan.v_blank && colour_sel;
	assign cram_addr = bus_side ? req.addr[2:0] : colnum;

	////////////////////
	// colour ram
	////////////////////
	always_ff @(posedge clk_10M)
	begin
		if (bus_side && req.write)
			cram[cram_addr] <= req.wdata[3:0];
		palette_data <= cram[cram_addr];
	end

	// rgb latch, palette bits are active low
	always_ff @(posedge clk_10M or posedge reset)
	begin
		if (reset)
			rgb_latch <= '0;
		else if (scan.ce_5m)
		begin
			rgb_latch.r <= {8{!palette_data[3]}};
			rgb_latch.g <= {8{!palette_data[2]}};
			rgb_latch.b <= {8{!palette_data[1]}};
		end
	end

	// black whenever either blank is up
	assign rgb = (scan.h_blank || scan.v_blank) ? '0 : rgb_latch;

endmodule

// ==== verilog/player_controls.sv ====
`timescale 1ns/1ns

module player_controls (
	input logic clk_10M,
	input logic reset,
	input missile_pkg::bus_req_t req,
	input logic out_sel,
	input missile_pkg::buttons_t buttons,
	input missile_pkg::trackball_t trackball,
	output logic [missile_pkg::data_w-1:0] in0,
	output logic [6:0] in1_low
);

	// control bit 0, selects trackball on in0
	logic ctrld;
	missile_pkg::trackball_t tb_meta;
	missile_pkg::trackball_t tb_sync;
	missile_pkg::trackball_t tb_last;
	logic [3:0] count_v;
	logic [3:0] count_h;

	// one step of a mod-16 count, dir high counts down
	function automatic logic [3:0] step(
		input logic [3:0] count,
		input logic rise,
		input logic dir
	);
		if (!rise)
			return count;
		return dir ? count - 4'd1 : count + 4'd1;
	endfunction

	////////////////////
	// latch and counters
	////////////////////
	always_ff @(posedge clk_10M or posedge reset)
	begin
		if (reset)
		begin
			ctrld <= 1'b0;
			tb_meta <= '0;
			tb_sync <= '0;
			tb_last <= '0;
			count_v <= '0;
			count_h <= '0;
		end
		else
		begin
			if (out_sel)
				ctrld <= req.wdata[0];
			// two flop synchronizer then edge history
			tb_meta <= trackball;
			tb_sync <= tb_meta;
			tb_last <= tb_sync;
			if (ctrld)
			begin
				count_v <= step(count_v, tb_sync.v_clk && !tb_last.v_clk, tb_sync.v_dir);
				count_h <= step(count_h, tb_sync.h_clk && !tb_last.h_clk, tb_sync.h_dir);
			end
		end
	end

	// switches read back inverted
	assign in0 = ctrld ? {count_v, count_h} :
		{!buttons.coin, 2'b11, !buttons.start_1, !buttons.start_2,
		!buttons.fire_l_2, !buttons.fire_c_2, !buttons.fire_r_2};
	assign in1_low = {4'b1111, !buttons.fire_l_1, !buttons.fire_c_1, !buttons.fire_r_1};

endmodule

// ==== verilog/missile_video_top.sv ====
`timescale 1ns/1ns

module missile_video_top (
	input logic clk_10M,
	input logic reset,
	input missile_pkg::bus_req_t bus,
	input missile_pkg::buttons_t buttons,
	input missile_pkg::trackball_t trackball,
	output logic [missile_pkg::data_w-1:0] read_data,
	output logic read_valid,
	output missile_pkg::rgb_t rgb,
	output logic h_sync,
	output logic v_sync
);

	missile_pkg::chip_sel_t sel;
	missile_pkg::chip_sel_t sel_q;
	missile_pkg::scan_t scan;
	missile_pkg::colnum_t colnum;
	missile_pkg::palette_t palette_data;
	logic [missile_pkg::vram_addr_w-1:0] video_addr;
	logic [missile_pkg::data_w-1:0] video_data;
	logic [missile_pkg::data_w-1:0] cpu_data;
	logic [missile_pkg::data_w-1:0] in0;
	logic [6:0] in1_low;
	logic [missile_pkg::data_w-1:0] read_mux;
	logic read_q;

	scan_timer u_scan (.clk_10M, .reset, .scan, .h_sync, .v_sync);

	address_decoder u_decode (.req(bus), .sel);

	bitmap_ram u_bitmap (.clk_10M, .req(bus), .sel, .video_addr, .video_data, .cpu_data);

	pixel_shifter u_shift (.clk_10M, .reset, .scan, .video_data, .video_addr, .colnum);

	colour_palette u_palette (.clk_10M, .reset, .scan, .req(bus), .colour_sel(sel.colour),
		.colnum, .palette_data, .rgb);

	player_controls u_controls (.clk_10M, .reset, .req(bus), .out_sel(sel.out_latch),
		.buttons, .trackball, .in0, .in1_low);

	////////////////////
	// read pipeline
	////////////////////
	// sources are registered at edge n, selected at n+1
	always_comb
	begin
		if (sel_q.ram || sel_q.pixel_2col || sel_q.pixel_3col)
			read_mux = cpu_data;
		else if (sel_q.in0)
			read_mux = in0;
		else if (sel_q.in1)
			read_mux = {scan.v_blank, in1_low};
		else if (sel_q.colour)
			read_mux = {4'h0, palette_data};
		else
			// unmapped reads float high
			read_mux = 8'hFF;
	end

	always_ff @(posedge clk_10M or posedge reset)
	begin
		if (reset)
		begin
			read_q <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_q <= bus.read;
			read_valid <= read_q;
		end
	end

	always_ff @(posedge clk_10M)
	begin
		sel_q <= sel;
		if (read_q)
			read_data <= read_mux;
	end

	// master never reads and writes in one cycle
	bus_one_op: assert property (@(posedge clk_10M) disable iff (reset)
		!(bus.write && bus.read));

endmodule

// ==== testbench/tb_missile_checks.svh ====
////////////////////
// reference model
////////////////////

// byte index for each access mode
function automatic int store_index(input logic [15:0] addr, input logic madsel);
	if (madsel && addr[15:13] == 3'b111)
		// third colour lines fold into 0x200..0x5ff, addr[12] picks the odd byte
		return (addr[11] ? 'h400 : 'h200) + 2 * addr[10:3] + addr[12];
	else if (madsel)
		return addr >> 2;
	else
		return addr[13:0];
endfunction

// masked write into the byte model
function automatic void store_write(input logic [15:0] addr, input logic [7:0] data,
	input logic madsel);
	int idx;
	idx = store_index(addr, madsel);
	if (madsel && addr[15:13] == 3'b111)
		store_model[idx][addr[2:0]] = data[5];
	else if (madsel)
	begin
		// pixel pair, one bit per nibble
		store_model[idx][{1'b0, addr[1:0]}] = data[6];
		store_model[idx][{1'b1, addr[1:0]}] = data[7];
	end
	else
		store_model[idx] = data;
endfunction

// expected read byte, unused bits high
function automatic logic [7:0] store_read(input logic [15:0] addr, input logic madsel);
	int idx;
	idx = store_index(addr, madsel);
	if (madsel && addr[15:13] == 3'b111)
		return {2'b11, store_model[idx][addr[2:0]], 5'b11111};
	else if (madsel)
		return {store_model[idx][{1'b1, addr[1:0]}], store_model[idx][{1'b0, addr[1:0]}],
			6'b111111};
	else
		return store_model[idx];
endfunction

// switches are active high here, read back inverted
function automatic logic [7:0] expected_in0(input missile_pkg::buttons_t b);
	return {!b.coin, 2'b11, !b.start_1, !b.start_2, !b.fire_l_2, !b.fire_c_2, !b.fire_r_2};
endfunction

function automatic logic [7:0] expected_in1(input missile_pkg::buttons_t b, input logic vb);
	return {vb, 4'b1111, !b.fire_l_1, !b.fire_c_1, !b.fire_r_1};
endfunction

// scan position from clocks since reset, one dot per two clocks
function automatic logic ref_v_blank(input int c);
	return (c / (2 * int'(missile_pkg::line_dots))) % missile_pkg::frame_lines
		< int'(missile_pkg::vblank_lines);
endfunction

function automatic logic ref_blank(input int c);
	return (c / 2) % int'(missile_pkg::line_dots) >= int'(missile_pkg::active_dots)
		|| ref_v_blank(c);
endfunction

// palette bits active low, black in blank
function automatic missile_pkg::rgb_t ref_rgb(input missile_pkg::palette_t word,
	input logic blank);
	missile_pkg::rgb_t colour;
	colour = '0;
	if (!blank)
	begin
		colour.r = word[3] ? 8'h00 : 8'hFF;
		colour.g = word[2] ? 8'h00 : 8'hFF;
		colour.b = word[1] ? 8'h00 : 8'hFF;
	end
	return colour;
endfunction

////////////////////
// compare tasks
////////////////////
task automatic abort_run();
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_byte(input string name, input logic [missile_pkg::data_w-1:0] got,
	input logic [missile_pkg::data_w-1:0] exp);
	if (got !== exp)
	begin
		$display("ERROR %s: got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_rgb(input string name, input missile_pkg::rgb_t got,
	input missile_pkg::rgb_t exp);
	if (got !== exp)
	begin
		$display("ERROR %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
		abort_run();
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp)
	begin
		$display("ERROR %s: got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

// ==== testbench/tb_missile.sv ====
`timescale 1ns/1ns

module tb_missile;

	localparam int timeout_cycles = 400000;
	localparam int line_cycles = 640;
	localparam int frame_cycles = 163840;

	logic clk_10M;
	logic reset;
	missile_pkg::bus_req_t bus;
	missile_pkg::buttons_t buttons;
	missile_pkg::trackball_t trackball;
	logic [missile_pkg::data_w-1:0] read_data;
	logic read_valid;
	missile_pkg::rgb_t rgb;
	logic h_sync;
	logic v_sync;

	int seed;
	// clocks since reset release
	int cyc = 0;
	logic [7:0] store_model [0:2**missile_pkg::vram_addr_w-1];
	missile_pkg::palette_t palette_model [0:7];
	missile_pkg::palette_t shown_palette;
	logic [3:0] count_v_model;
	logic [3:0] count_h_model;
	logic [7:0] expected_q [$];
	logic [15:0] addr_list [0:63];
	logic h_prev = 1'b0;
	logic v_prev = 1'b0;
	logic h_seen = 1'b0;
	logic v_seen = 1'b0;
	int h_last;
	int v_last;

	`include "tb_missile_checks.svh"

	missile_video_top uut (.clk_10M, .reset, .bus, .buttons, .trackball, .read_data,
		.read_valid, .rgb, .h_sync, .v_sync);

	initial
	begin
		clk_10M = 1'b0;
		forever #50 clk_10M = !clk_10M;
	end

	always @(posedge clk_10M or posedge reset)
	begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	always @(posedge clk_10M)
	begin
		if (cyc >= timeout_cycles)
		begin
			$display("timeout after %0d cycles, test sequence did not finish", cyc);
			abort_run();
		end
	end

	////////////////////
	// response checks
	////////////////////
	// one queued byte per read, in order
	always @(posedge clk_10M)
	begin
		if (!reset && read_valid)
		begin
			if (expected_q.size() == 0)
			begin
				$display("read_valid came with no read outstanding");
				abort_run();
			end
			else
				check_byte("read_data", read_data, expected_q.pop_front());
		end
	end

	// video checked mid-cycle over the second frame
	always @(negedge clk_10M)
	begin
		if (!reset && cyc >= frame_cycles && cyc < 2 * frame_cycles)
			check_rgb("rgb", rgb, ref_rgb(shown_palette, ref_blank(cyc)));
	end

	always @(negedge clk_10M)
	begin
		h_prev <= h_sync;
		if (!reset && h_sync && !h_prev)
		begin
			h_last <= cyc;
			h_seen <= 1'b1;
			if (h_seen)
				check_count("h_sync period", cyc - h_last, line_cycles);
		end
	end

	always @(negedge clk_10M)
	begin
		v_prev <= v_sync;
		if (!reset && v_sync && !v_prev)
		begin
			v_last <= cyc;
			v_seen <= 1'b1;
			if (v_seen)
				check_count("v_sync period", cyc - v_last, frame_cycles);
		end
	end

	////////////////////
	// bus stimulus
	////////////////////
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data,
		input logic madsel);
		missile_pkg::bus_req_t req;
		req = '0;
		req.addr = addr;
		req.wdata = data;
		req.write = 1'b1;
		req.madsel = madsel;
		@(posedge clk_10M);
		bus <= req;
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic madsel,
		input logic [7:0] expected);
		missile_pkg::bus_req_t req;
		req = '0;
		req.addr = addr;
		req.read = 1'b1;
		req.madsel = madsel;
		@(posedge clk_10M);
		bus <= req;
		expected_q.push_back(expected);
	endtask

	task automatic bus_idle();
		@(posedge clk_10M);
		bus <= '0;
	endtask

	task automatic ram_write(input logic [15:0] addr, input logic [7:0] data,
		input logic madsel);
		bus_write(addr, data, madsel);
		store_write(addr, data, madsel);
	endtask

	task automatic wait_until(input int target);
		while (cyc < target)
			@(posedge clk_10M);
	endtask

	// trackball counts, then switch ports
	task automatic run_control_test();
		missile_pkg::trackball_t pulse;
		missile_pkg::buttons_t pressed;
		logic [31:0] rnd;
		logic dir;
		bus_write(16'h4800, 8'h01, 1'b0);
		bus_idle();
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			dir = rnd[1];
			pulse = '0;
			if (rnd[0])
			begin
				pulse.v_clk = 1'b1;
				pulse.v_dir = dir;
				count_v_model = dir ? count_v_model - 4'd1 : count_v_model + 4'd1;
			end
			else
			begin
				pulse.h_clk = 1'b1;
				pulse.h_dir = dir;
				count_h_model = dir ? count_h_model - 4'd1 : count_h_model + 4'd1;
			end
			@(posedge clk_10M);
			trackball <= pulse;
			repeat (3) @(posedge clk_10M);
			trackball <= '0;
			repeat (3) @(posedge clk_10M);
		end
		bus_read(16'h4800, 1'b0, {count_v_model, count_h_model});
		bus_write(16'h4800, 8'h00, 1'b0);
		bus_idle();
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			pressed = rnd[8:0];
			@(posedge clk_10M);
			buttons <= pressed;
			bus_read(16'h4800, 1'b0, expected_in0(pressed));
			// deep inside line 0, so v_blank is settled
			bus_read(16'h4900, 1'b0, expected_in1(pressed, ref_v_blank(cyc)));
			bus_idle();
		end
	endtask

	task automatic run_palette_test();
		logic [31:0] rnd;
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			palette_model[i] = rnd[3:0];
			bus_write(16'h4B00 + i, {4'h0, rnd[3:0]}, 1'b0);
		end
		for (int i = 0; i < 8; i++)
			bus_read(16'h4B00 + i, 1'b0, {4'h0, palette_model[i]});
		bus_idle();
	endtask

	// mode 0 byte, 1 two-colour, 2 third-colour
	task automatic run_ram_test(input int mode);
		logic [31:0] rnd;
		logic [15:0] addr;
		for (int i = 0; i < 64; i++)
		begin
			rnd = $random(seed);
			addr = rnd[15:0];
			if (mode == 0)
				addr[15:14] = 2'b00;
			else if (mode == 2)
				addr[15:13] = 3'b111;
			else if (addr[15:13] == 3'b111)
				addr[15] = 1'b0;
			addr_list[i] = addr;
			ram_write(addr, rnd[23:16], mode != 0);
		end
		// back to back, two reads in flight
		for (int i = 0; i < 64; i++)
			bus_read(addr_list[i], mode != 0, store_read(addr_list[i], mode != 0));
		// whole bytes show the untouched bits
		if (mode != 0)
		begin
			for (int i = 0; i < 64; i++)
			begin
				addr = 16'(store_index(addr_list[i], 1'b1));
				bus_read(addr, 1'b0, store_read(addr, 1'b0));
			end
		end
		bus_idle();
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial
	begin
		logic [31:0] rnd;
		seed = 94995;
		reset = 1'b1;
		bus = '0;
		buttons = '0;
		trackball = '0;
		shown_palette = '0;
		count_v_model = '0;
		count_h_model = '0;
		repeat (3) @(posedge clk_10M);
		reset <= 1'b0;

		// frame 0 v_blank
		run_control_test();
		run_palette_test();
		for (int a = 0; a < 2**missile_pkg::vram_addr_w; a++)
			ram_write(a[15:0], a[7:0] ^ a[13:6], 1'b0);
		bus_idle();

		// visible area, colour ram write dropped
		wait_until(30 * line_cycles);
		bus_write(16'h4B00, {4'h0, ~palette_model[0]}, 1'b0);
		// in1 top bit follows v_blank down
		bus_read(16'h4900, 1'b0, expected_in1(buttons, ref_v_blank(cyc)));
		bus_idle();
		run_ram_test(0);
		run_ram_test(1);
		run_ram_test(2);

		// all ones, so only colours 6 and 7 reach the screen
		for (int a = 0; a < 2**missile_pkg::vram_addr_w; a++)
			ram_write(a[15:0], 8'hFF, 1'b0);
		bus_idle();

		// frame 1 v_blank
		wait_until(frame_cycles + 8);
		bus_read(16'h4B00, 1'b0, {4'h0, palette_model[0]});
		rnd = $random(seed);
		shown_palette = rnd[3:0];
		palette_model[6] = rnd[3:0];
		palette_model[7] = rnd[3:0];
		bus_write(16'h4B06, {4'h0, rnd[3:0]}, 1'b0);
		bus_write(16'h4B07, {4'h0, rnd[3:0]}, 1'b0);
		bus_read(16'h4B06, 1'b0, {4'h0, palette_model[6]});
		bus_read(16'h4B07, 1'b0, {4'h0, palette_model[7]});
		bus_idle();

		wait_until(2 * frame_cycles + 8);
		if (expected_q.size() == 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("%0d reads never answered by read_valid", expected_q.size());
			abort_run();
		end
	end

endmodule

// ==== src.f ====
+incdir+testbench
verilog/missile_pkg.sv
verilog/scan_timer.sv
verilog/address_decoder.sv
verilog/bitmap_ram.sv
verilog/pixel_shifter.sv
verilog/colour_palette.sv
verilog/player_controls.sv
verilog/missile_video_top.sv
testbench/tb_missile.sv
